//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module core_tb -Mdir obj_dir -o core_tb

run: compile
	./obj_dir/core_tb | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- rtl/core_pkg.sv
package core_pkg;

    // datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // major opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;

    // special group function codes
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    // decode to execute, 111 bits
    typedef struct packed {
        logic [xlen-1:0]       pc;
        alu_op_e               alu_op;
        logic [xlen-1:0]       src_a;
        logic [xlen-1:0]       src_b;
        logic [4:0]            shamt;
        logic [reg_addr_w-1:0] dest;
        logic                  writes;
    } de_payload_t;

    // execute to result, 70 bits
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] dest;
        logic                  writes;
        logic [xlen-1:0]       value;
    } wb_payload_t;

endpackage

//--- rtl/core_top.sv
`timescale 1ns/1ns

module core_top (
    input  logic                            aclk,
    input  logic                            rst,
    input  logic                            inst_valid,
    input  logic [core_pkg::xlen-1:0]       inst_pc,
    input  logic [31:0]                     inst_word,
    output logic                            inst_ready,
    output logic [core_pkg::xlen-1:0]       debug_wb_pc,
    output logic [3:0]                      debug_wb_rf_wen,
    output logic [core_pkg::reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [core_pkg::xlen-1:0]       debug_wb_rf_wdata
);

    logic                            ds_valid;
    logic                            ds_allowin;
    core_pkg::de_payload_t           ds_payload;
    logic                            es_valid;
    logic                            es_allowin;
    core_pkg::de_payload_t           es_payload;
    core_pkg::wb_payload_t           es_result;
    logic                            ws_valid;
    core_pkg::wb_payload_t           ws_payload;
    logic [core_pkg::reg_addr_w-1:0] rs_addr;
    logic [core_pkg::reg_addr_w-1:0] rt_addr;
    logic [core_pkg::xlen-1:0]       rs_data;
    logic [core_pkg::xlen-1:0]       rt_data;
    logic [core_pkg::reg_addr_w-1:0] ws_dest;
    logic                            ws_writes;

    decode_stage decode_stage_i (
        .aclk(aclk), .rst(rst),
        .inst_valid(inst_valid), .inst_pc(inst_pc), .inst_word(inst_word),
        .inst_ready(inst_ready),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
        .ex_valid(es_valid), .ex_writes(es_payload.writes), .ex_dest(es_payload.dest),
        .wb_valid(ws_valid), .wb_writes(ws_writes), .wb_dest(ws_dest),
        .de_valid(ds_valid), .de_payload(ds_payload), .de_allowin(ds_allowin)
    );

    stage_reg #(.payload_t(core_pkg::de_payload_t)) de_ex_reg (
        .aclk(aclk), .rst(rst),
        .in_valid(ds_valid), .in_payload(ds_payload), .in_allowin(ds_allowin),
        .out_valid(es_valid), .out_payload(es_payload), .out_allowin(es_allowin)
    );

    execute_stage execute_stage_i (
        .de_payload (es_payload),
        .wb_payload (es_result )
    );

    // result stage never back-pressures
    stage_reg #(.payload_t(core_pkg::wb_payload_t)) ex_wb_reg (
        .aclk(aclk), .rst(rst),
        .in_valid(es_valid), .in_payload(es_result), .in_allowin(es_allowin),
        .out_valid(ws_valid), .out_payload(ws_payload), .out_allowin(1'b1)
    );

    result_stage result_stage_i (
        .aclk(aclk), .rst(rst),
        .wb_valid(ws_valid), .wb_payload(ws_payload),
        .rs_addr(rs_addr), .rt_addr(rt_addr), .rs_data(rs_data), .rt_data(rt_data),
        .wb_dest(ws_dest), .wb_writes(ws_writes),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic                            aclk,
    input  logic                            rst,
    input  logic                            inst_valid,
    input  logic [core_pkg::xlen-1:0]       inst_pc,
    input  logic [31:0]                     inst_word,
    output logic                            inst_ready,
    output logic [core_pkg::reg_addr_w-1:0] rs_addr,
    output logic [core_pkg::reg_addr_w-1:0] rt_addr,
    input  logic [core_pkg::xlen-1:0]       rs_data,
    input  logic [core_pkg::xlen-1:0]       rt_data,
    input  logic                            ex_valid,
    input  logic                            ex_writes,
    input  logic [core_pkg::reg_addr_w-1:0] ex_dest,
    input  logic                            wb_valid,
    input  logic                            wb_writes,
    input  logic [core_pkg::reg_addr_w-1:0] wb_dest,
    output logic                            de_valid,
    output core_pkg::de_payload_t           de_payload,
    input  logic                            de_allowin
);

    logic                            buf_valid;
    logic [core_pkg::xlen-1:0]       buf_pc;
    logic [31:0]                     buf_word;
    logic [5:0]                      opcode;
    logic [5:0]                      funct;
    logic [15:0]                     imm;
    logic [core_pkg::reg_addr_w-1:0] dest;
    core_pkg::alu_op_e               alu_op;
    logic                            use_imm;
    logic                            zext;
    logic                            rtype;
    logic                            known;
    logic                            rs_used;
    logic                            rt_used;
    logic                            ex_busy;
    logic                            wb_busy;
    logic                            hazard;
    logic                            release_buf;

    assign release_buf = de_valid && de_allowin;
    assign inst_ready  = !buf_valid || release_buf;

    always_ff @(posedge aclk) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (inst_valid && inst_ready) begin
            buf_valid <= 1'b1;
        end else if (release_buf) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (inst_valid && inst_ready) begin
            buf_pc   <= inst_pc;
            buf_word <= inst_word;
        end
    end

    assign opcode  = buf_word[31:26];
    assign rs_addr = buf_word[25:21];
    assign rt_addr = buf_word[20:16];
    assign funct   = buf_word[5:0];
    assign imm     = buf_word[15:0];

    always_comb begin
        alu_op  = core_pkg::alu_add;
        use_imm = 1'b1;
        zext    = 1'b0;
        rtype   = 1'b0;
        known   = 1'b1;
        rs_used = 1'b1;
        rt_used = 1'b0;
        case (opcode)
            core_pkg::op_special: begin
                use_imm = 1'b0;
                rtype   = 1'b1;
                rt_used = 1'b1;
                case (funct)
                    core_pkg::fn_addu: alu_op = core_pkg::alu_add;
                    core_pkg::fn_subu: alu_op = core_pkg::alu_sub;
                    core_pkg::fn_and:  alu_op = core_pkg::alu_and;
                    core_pkg::fn_or:   alu_op = core_pkg::alu_or;
                    core_pkg::fn_xor:  alu_op = core_pkg::alu_xor;
                    core_pkg::fn_nor:  alu_op = core_pkg::alu_nor;
                    core_pkg::fn_slt:  alu_op = core_pkg::alu_slt;
                    core_pkg::fn_sltu: alu_op = core_pkg::alu_sltu;
                    // shifts take rt and shamt only
                    core_pkg::fn_sll: begin
                        alu_op  = core_pkg::alu_sll;
                        rs_used = 1'b0;
                    end
                    core_pkg::fn_srl: begin
                        alu_op  = core_pkg::alu_srl;
                        rs_used = 1'b0;
                    end
                    core_pkg::fn_sra: begin
                        alu_op  = core_pkg::alu_sra;
                        rs_used = 1'b0;
                    end
                    default: begin
                        known   = 1'b0;
                        rs_used = 1'b0;
                        rt_used = 1'b0;
                    end
                endcase
            end
            core_pkg::op_addiu: alu_op = core_pkg::alu_add;
            core_pkg::op_slti:  alu_op = core_pkg::alu_slt;
            core_pkg::op_sltiu: alu_op = core_pkg::alu_sltu;
            core_pkg::op_andi: begin
                alu_op = core_pkg::alu_and;
                zext   = 1'b1;
            end
            core_pkg::op_ori: begin
                alu_op = core_pkg::alu_or;
                zext   = 1'b1;
            end
            core_pkg::op_xori: begin
                alu_op = core_pkg::alu_xor;
                zext   = 1'b1;
            end
            core_pkg::op_lui: begin
                alu_op  = core_pkg::alu_lui;
                zext    = 1'b1;
                rs_used = 1'b0;
            end
            default: begin
                known   = 1'b0;
                rs_used = 1'b0;
            end
        endcase
    end

    assign dest = rtype ? buf_word[15:11] : rt_addr;

    // stall until both later stages are clear of our sources
    assign ex_busy = ex_valid && ex_writes;
    assign wb_busy = wb_valid && wb_writes;
    assign hazard  = buf_valid && (
        (rs_used && ((ex_busy && ex_dest == rs_addr) || (wb_busy && wb_dest == rs_addr))) ||
        (rt_used && ((ex_busy && ex_dest == rt_addr) || (wb_busy && wb_dest == rt_addr))));

    assign de_valid = buf_valid && !hazard;

    always_comb begin
        de_payload.pc     = buf_pc;
        de_payload.alu_op = alu_op;
        de_payload.src_a  = rs_data;
        de_payload.src_b  = rt_data;
        if (use_imm) begin
            de_payload.src_b = zext ? {16'b0, imm} : {{16{imm[15]}}, imm};
        end
        de_payload.shamt  = buf_word[10:6];
        de_payload.dest   = dest;
        de_payload.writes = known && dest != '0;
    end

    // upstream holds an offered instruction until it is taken
    a_inst_hold: assert property (
        @(posedge aclk) disable iff (rst)
        inst_valid && !inst_ready |=> inst_valid && $stable(inst_pc) && $stable(inst_word)
    ) else $error("decode_stage: instruction changed or withdrawn before it was taken");

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  core_pkg::de_payload_t de_payload,
    output core_pkg::wb_payload_t wb_payload
);

    logic [core_pkg::xlen-1:0] a;
    logic [core_pkg::xlen-1:0] b;
    logic [4:0]                sa;
    logic [core_pkg::xlen-1:0] result;

    assign a  = de_payload.src_a;
    assign b  = de_payload.src_b;
    assign sa = de_payload.shamt;

    always_comb begin
        case (de_payload.alu_op)
            core_pkg::alu_add: begin
                result = a + b;
            end
            core_pkg::alu_sub: begin
                result = a - b;
            end
            core_pkg::alu_and: begin
                result = a & b;
            end
            core_pkg::alu_or: begin
                result = a | b;
            end
            core_pkg::alu_xor: begin
                result = a ^ b;
            end
            core_pkg::alu_nor: begin
                result = ~(a | b);
            end
            core_pkg::alu_slt: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            core_pkg::alu_sltu: begin
                result = {31'b0, a < b};
            end
            // shifts act on rt
            core_pkg::alu_sll: begin
                result = b << sa;
            end
            core_pkg::alu_srl: begin
                result = b >> sa;
            end
            core_pkg::alu_sra: begin
                result = $unsigned($signed(b) >>> sa);
            end
            core_pkg::alu_lui: begin
                result = {b[15:0], 16'b0};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    always_comb begin
        wb_payload.pc     = de_payload.pc;
        wb_payload.dest   = de_payload.dest;
        wb_payload.writes = de_payload.writes;
        wb_payload.value  = result;
    end

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic                            aclk,
    input  logic                            rst,
    input  logic                            we,
    input  logic [core_pkg::reg_addr_w-1:0] waddr,
    input  logic [core_pkg::xlen-1:0]       wdata,
    input  logic [core_pkg::reg_addr_w-1:0] raddr_a,
    input  logic [core_pkg::reg_addr_w-1:0] raddr_b,
    output logic [core_pkg::xlen-1:0]       rdata_a,
    output logic [core_pkg::xlen-1:0]       rdata_b
);

    // $0 has no storage
    logic [core_pkg::xlen-1:0] regs [31:1];

    always_ff @(posedge aclk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        if (raddr_a == '0) begin
            rdata_a = '0;
        end else begin
            rdata_a = regs[raddr_a];
        end
    end

    always_comb begin
        if (raddr_b == '0) begin
            rdata_b = '0;
        end else begin
            rdata_b = regs[raddr_b];
        end
    end

    // decode already drops the write flag for $0
    a_no_zero_write: assert property (
        @(posedge aclk) disable iff (rst)
        we |-> waddr != '0
    ) else $error("regfile: write attempted to register 0");

endmodule

//--- rtl/result_stage.sv
`timescale 1ns/1ns

module result_stage (
    input  logic                            aclk,
    input  logic                            rst,
    input  logic                            wb_valid,
    input  core_pkg::wb_payload_t           wb_payload,
    input  logic [core_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [core_pkg::reg_addr_w-1:0] rt_addr,
    output logic [core_pkg::xlen-1:0]       rs_data,
    output logic [core_pkg::xlen-1:0]       rt_data,
    output logic [core_pkg::reg_addr_w-1:0] wb_dest,
    output logic                            wb_writes,
    output logic [core_pkg::xlen-1:0]       debug_wb_pc,
    output logic [3:0]                      debug_wb_rf_wen,
    output logic [core_pkg::reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [core_pkg::xlen-1:0]       debug_wb_rf_wdata
);

    logic rf_we;

    assign rf_we = wb_valid && wb_payload.writes;

    regfile regfile_i (
        .aclk    (aclk             ),
        .rst     (rst              ),
        .we      (rf_we            ),
        .waddr   (wb_payload.dest  ),
        .wdata   (wb_payload.value ),
        .raddr_a (rs_addr          ),
        .raddr_b (rt_addr          ),
        .rdata_a (rs_data          ),
        .rdata_b (rt_data          )
    );

    // decode qualifies these with wb_valid
    assign wb_dest   = wb_payload.dest;
    assign wb_writes = wb_payload.writes;

    // trace port
    assign debug_wb_pc       = wb_payload.pc;
    assign debug_wb_rf_wen   = {4{rf_we}};
    assign debug_wb_rf_wnum  = wb_payload.dest;
    assign debug_wb_rf_wdata = wb_payload.value;

endmodule

//--- rtl/stage_reg.sv
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     aclk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     in_allowin,
    output logic     out_valid,
    output payload_t out_payload,
    input  logic     out_allowin
);

    logic     valid_q;
    payload_t payload_q;

    // empty, or the held entry moves on this cycle
    assign in_allowin = !valid_q || out_allowin;

    always_ff @(posedge aclk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_allowin) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (in_valid && in_allowin) begin
            payload_q <= in_payload;
        end
    end

    assign out_valid   = valid_q;
    assign out_payload = payload_q;

    // downstream sees a steady entry while it holds us off
    a_hold_stable: assert property (
        @(posedge aclk) disable iff (rst)
        out_valid && !out_allowin |=> out_valid && $stable(out_payload)
    ) else $error("stage_reg: payload changed while held");

endmodule

//--- sim.f
rtl/core_pkg.sv
rtl/regfile.sv
rtl/stage_reg.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/core_top.sv
verification/core_tb.sv

//--- verification/core_golden.txt
# I <pc hex> <instruction hex> <max idle cycles before it, decimal>
# W <pc hex> <register decimal> <value hex>, in retirement order
I 00000000 3c018000 3  lui   $1, 0x8000
I 00000004 3402f0f0 3  ori   $2, $0, 0xf0f0
I 00000008 2403fff6 3  addiu $3, $0, -10
I 0000000c 3064ff00 0  andi  $4, $3, 0xff00
I 00000010 3845ffff 0  xori  $5, $2, 0xffff
I 00000014 28660001 3  slti  $6, $3, 1
I 00000018 2c47ffff 3  sltiu $7, $2, -1
I 0000001c 00234021 3  addu  $8, $1, $3
I 00000020 00454823 3  subu  $9, $2, $5
I 00000024 00455027 3  nor   $10, $2, $5
I 00000028 0022582a 3  slt   $11, $1, $2
I 0000002c 0022602b 3  sltu  $12, $1, $2
I 00000030 00016903 3  sra   $13, $1, 4
I 00000034 00017102 3  srl   $14, $1, 4
I 00000038 00027a00 3  sll   $15, $2, 8
I 0000003c 01ae8026 0  xor   $16, $13, $14
I 00000040 24200005 0  addiu $0, $1, 5
I 00000044 fc0a1234 3  unknown opcode 0x3f
I 00000048 00028821 3  addu  $17, $0, $2
I 0000004c 022f9024 0  and   $18, $17, $15
I 00000050 02499825 0  or    $19, $18, $9
W 00000000 1 80000000
W 00000004 2 0000f0f0
W 00000008 3 fffffff6
W 0000000c 4 0000ff00
W 00000010 5 00000f0f
W 00000014 6 00000001
W 00000018 7 00000001
W 0000001c 8 7ffffff6
W 00000020 9 0000e1e1
W 00000024 10 ffff0000
W 00000028 11 00000001
W 0000002c 12 00000000
W 00000030 13 f8000000
W 00000034 14 08000000
W 00000038 15 00f0f000
W 0000003c 16 f0000000
W 00000048 17 0000f0f0
W 0000004c 18 0000f000
W 00000050 19 0000f1e1

//--- verification/core_tb.sv
`timescale 1ns/1ns

module core_tb;

    localparam int clk_period      = 4;
    localparam int cycles_per_inst = 8;
    localparam int timeout_margin  = 50;

    logic        aclk;
    logic        rst;
    logic        inst_valid;
    logic [31:0] inst_pc;
    logic [31:0] inst_word;
    logic        inst_ready;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // instruction stream and expected trace from the golden file
    logic [31:0] i_pc [$];
    logic [31:0] i_word [$];
    int          i_gap [$];
    logic [31:0] w_pc [$];
    logic [31:0] w_num [$];
    logic [31:0] w_val [$];

    integer seed;
    int     errors = 0;
    int     wb_count = 0;
    int     stall_cycles = 0;
    int     cycle_count;
    int     timeout_limit = 0;
    bit     done = 1'b0;
    bit     loaded;

    core_top core_top_i (
        .aclk              (aclk             ),
        .rst               (rst              ),
        .inst_valid        (inst_valid       ),
        .inst_pc           (inst_pc          ),
        .inst_word         (inst_word        ),
        .inst_ready        (inst_ready       ),
        .debug_wb_pc       (debug_wb_pc      ),
        .debug_wb_rf_wen   (debug_wb_rf_wen  ),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum ),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        aclk = 1'b0;
        forever #(clk_period / 2) aclk = ~aclk;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic load_golden(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        int          gap;
        ok = 1'b0;
        fd = $fopen("verification/core_golden.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] == "I") begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h %d", a, b, gap);
                    i_pc.push_back(a);
                    i_word.push_back(b);
                    i_gap.push_back(gap);
                    ok = ok && n == 3;
                end else if (line.len() > 1 && line[0] == "W") begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %d %h", a, b, c);
                    w_pc.push_back(a);
                    w_num.push_back(b);
                    w_val.push_back(c);
                    ok = ok && n == 3;
                end
            end
            $fclose(fd);
            ok = ok && i_pc.size() > 0;
        end
    endtask

    // idle gap of 0..3 cycles, capped by the golden file for dependency bursts
    task automatic send_inst(input logic [31:0] pc, input logic [31:0] word,
                             input int max_gap);
        int rnd;
        int gap;
        rnd = $random(seed);
        gap = rnd & 3;
        if (gap > max_gap) begin
            gap = max_gap;
        end
        repeat (gap) @(negedge aclk);
        inst_valid = 1'b1;
        inst_pc    = pc;
        inst_word  = word;
        while (!inst_ready) begin
            stall_cycles++;
            @(negedge aclk);
        end
        // transfer happens on the rising edge in between
        @(negedge aclk);
        inst_valid = 1'b0;
    endtask

    // retirement monitor
    always @(posedge aclk) begin
        if (!rst && debug_wb_rf_wen != 4'h0) begin
            if (wb_count < w_pc.size()) begin
                check($sformatf("write %0d pc", wb_count), w_pc[wb_count], debug_wb_pc);
                check($sformatf("write %0d wen", wb_count), 32'hf, {28'b0, debug_wb_rf_wen});
                check($sformatf("write %0d wnum", wb_count), w_num[wb_count],
                      {27'b0, debug_wb_rf_wnum});
                check($sformatf("write %0d wdata", wb_count), w_val[wb_count],
                      debug_wb_rf_wdata);
            end else begin
                errors++;
                $display("register write to $%0d at pc %h came after the last expected write",
                         debug_wb_rf_wnum, debug_wb_pc);
            end
            wb_count++;
        end
    end

    initial begin
        cycle_count = 0;
        wait (timeout_limit > 0);
        while (!done && cycle_count < timeout_limit) begin
            @(posedge aclk);
            cycle_count++;
        end
        if (!done) begin
            $display("timeout after %0d cycles: the trace did not finish, %0d of %0d writes seen",
                     cycle_count, wb_count, w_pc.size());
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst_pc    = '0;
        inst_word  = '0;
        seed       = 32'h8570_2979;
        load_golden(loaded);
        if (!loaded) begin
            $display("could not read a valid instruction stream from verification/core_golden.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            timeout_limit = cycles_per_inst * i_pc.size() + timeout_margin;
            repeat (2) @(negedge aclk);
            rst = 1'b0;
            @(negedge aclk);
            check("reset wen", 32'h0, {28'b0, debug_wb_rf_wen});
            check("reset ready", 32'h1, {31'b0, inst_ready});
            foreach (i_pc[k]) begin
                send_inst(i_pc[k], i_word[k], i_gap[k]);
            end
            while (wb_count < w_pc.size()) begin
                @(negedge aclk);
            end
            // drain window to catch stray writes
            repeat (10) @(negedge aclk);
            done = 1'b1;
            check("write count", w_pc.size(), wb_count);
            if (stall_cycles == 0) begin
                errors++;
                $display("inst_ready never went low while inst_valid was high");
            end
            $display("errors: %0d, writes checked: %0d, stall cycles: %0d",
                     errors, wb_count, stall_cycles);
            if (errors == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule
